// File: source/gc_consts.svh
// Bit timing, idle length and controller ID defaults, included by the emulator RTL and testbench
`ifndef GC_CONSTS_SVH
`define GC_CONSTS_SVH

// Clock cycles in one quarter of an N-serial bit
// A whole bit on the wire is four quarters long
`define GC_QUARTER_CYCLES 4

// Quarters of unbroken high line that end a frame
// This must stay longer than the three high quarters of a one bit
`define GC_IDLE_QUARTERS 5

// Identification word that a standard controller returns for request 0x00
// The first byte 0x09 marks a standard pad with rumble support
`define GC_CONTROLLER_ID 24'h090000

`endif

// File: source/gc_proto_pkg.sv
// Joybus wire-protocol types shared by the controller FSM and the testbench request tasks
`default_nettype none

package gc_proto_pkg;

  // Request bytes sent by the console
  // The poll request is 0x40 0x03 followed by one flags byte
  typedef enum logic [7:0] {
    GC_CMD_ID       = 8'h00,
    GC_CMD_POLL     = 8'h40,
    GC_CMD_ORIGINS  = 8'h41,
    GC_CMD_POLL_ARG = 8'h03
  } gc_cmd_t;

  // States of the emulated controller
  // The three finishing states wait for the stop bit of a recognised request
  typedef enum logic [3:0] {
    S_IDLE,
    S_RX_CMD,
    S_RX_POLL_1,
    S_RX_POLL_2,
    S_FINISH_ID,
    S_FINISH_POLL,
    S_FINISH_ORIGINS,
    S_TX_BYTE,
    S_TX_WAIT,
    S_TX_STOPBIT
  } gc_state_e;

  // Last eight bytes of the get-origins reply
  // Both sticks report a centre of 0x80, both triggers rest at 0x00, then two 0x02 bytes
  localparam logic [63:0] GC_ORIGINS_TAIL = 64'h8080808000000202;

endpackage

`default_nettype wire

// File: source/gc_host_pkg.sv
// Host-side types for the pad-state registers, used by the register block, the top and the testbench
`default_nettype none

package gc_host_pkg;

  // Number of bytes in one pad-state report
  localparam int PAD_BYTES = 8;

  // Whole pad word as returned to a status poll
  // The byte that goes out first sits in bits 63:56
  typedef logic [PAD_BYTES*8-1:0] pad_state_t;

  // Host address of one pad byte
  // Index 0 selects the top byte, index 7 the bottom one
  typedef logic [$clog2(PAD_BYTES)-1:0] pad_byte_idx_t;

endpackage

`default_nettype wire

// File: source/gc_state_regs.sv
// Host-writable pad-state registers, staged byte by byte and committed to the controller in one step
`timescale 1ns/1ps
`default_nettype none

module gc_state_regs (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        host_write,
  input  wire                        host_commit,
  input  wire gc_host_pkg::pad_byte_idx_t host_addr,
  input  wire  [7:0]                 host_wdata,
  output gc_host_pkg::pad_state_t    pad_state
);

  import gc_host_pkg::*;

  // Staging bytes collect a new report while the live word keeps answering polls
  logic [7:0] staging [PAD_BYTES];

  // Byte writes from the host land in staging only
  always_ff @(posedge clk) begin
    if (host_write) begin
      staging[host_addr] <= host_wdata;
    end
  end

  // A commit copies all eight bytes at once so a poll never sees a half-updated report
  // A write in the same cycle reaches staging after the old bytes were copied
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pad_state <= '0;
    end else if (host_commit) begin
      for (int i = 0; i < PAD_BYTES; i++) begin
        pad_state[(PAD_BYTES-1-i)*8 +: 8] <= staging[i];
      end
    end
  end

  // A write with an unknown address would scramble an unpredictable staging byte
  assert property (@(posedge clk) disable iff (reset)
    host_write |-> !$isunknown(host_addr))
    else $error("host write with unknown address");

endmodule

`default_nettype wire

// File: source/n_serial_rx.sv
// N-serial receiver that turns the joybus line into start, byte, stop and error events for the FSM
`timescale 1ns/1ps
`default_nettype none
`include "gc_consts.svh"

module n_serial_rx (
  input  wire        clk,
  input  wire        reset,
  input  wire        line_in,
  output logic       rx_start,
  output logic       rx_stop,
  output logic       rx_error,
  output logic [7:0] rx_data,
  output logic       rx_strobe
);

  localparam int Q = `GC_QUARTER_CYCLES;
  // Bits are sampled in the middle, two quarters after the falling edge
  localparam int SAMPLE_AT = 2 * Q;
  // No valid symbol holds the line low for a whole bit
  localparam int LOW_LIMIT = 4 * Q;
  // Two sync flops and the event register add three cycles to the idle timer
  localparam int IDLE_AT = `GC_IDLE_QUARTERS * Q - 3;
  localparam int CNT_MAX = ((LOW_LIMIT > IDLE_AT) ? LOW_LIMIT : IDLE_AT) + 1;
  localparam int CNT_W = $clog2(CNT_MAX + 1);

  logic             sync1;
  logic             sync2;
  logic             line_q;
  logic [CNT_W-1:0] fall_cnt;
  logic [CNT_W-1:0] high_cnt;
  logic             idle;
  logic             in_frame;
  logic [2:0]       bit_cnt;
  logic [7:0]       shreg;
  logic             fall;
  logic             sample_now;
  logic             low_too_long;
  logic             idle_hit;

  assign fall         = line_q & ~sync2;
  assign sample_now   = in_frame & ~fall & (fall_cnt == CNT_W'(SAMPLE_AT));
  assign low_too_long = in_frame & ~fall & ~sync2 & (fall_cnt == CNT_W'(LOW_LIMIT));
  assign idle_hit     = sync2 & (high_cnt == CNT_W'(IDLE_AT));

  // The line idles high, so the synchronizer starts out high
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync1  <= 1'b1;
      sync2  <= 1'b1;
      line_q <= 1'b1;
    end else begin
      sync1  <= line_in;
      sync2  <= sync1;
      line_q <= sync2;
    end
  end

  // Cycles since the last fall, and cycles of unbroken high, both saturating
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fall_cnt <= CNT_W'(CNT_MAX);
      high_cnt <= '0;
    end else begin
      if (fall) begin
        fall_cnt <= CNT_W'(1);
      end else if (fall_cnt != CNT_W'(CNT_MAX)) begin
        fall_cnt <= fall_cnt + 1'b1;
      end
      if (!sync2) begin
        high_cnt <= '0;
      end else if (high_cnt != CNT_W'(CNT_MAX)) begin
        high_cnt <= high_cnt + 1'b1;
      end
    end
  end

  // Frame tracking and the four event pulses
  // A frame only opens on a fall that follows idle, so a broken frame is skipped to its end
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      idle      <= 1'b0;
      in_frame  <= 1'b0;
      bit_cnt   <= '0;
      rx_start  <= 1'b0;
      rx_stop   <= 1'b0;
      rx_error  <= 1'b0;
      rx_strobe <= 1'b0;
    end else begin
      rx_start  <= 1'b0;
      rx_stop   <= 1'b0;
      rx_error  <= 1'b0;
      rx_strobe <= 1'b0;
      if (fall) begin
        if (idle) begin
          rx_start <= 1'b1;
          in_frame <= 1'b1;
          bit_cnt  <= '0;
        end
        idle <= 1'b0;
      end else if (low_too_long) begin
        rx_error <= 1'b1;
        in_frame <= 1'b0;
      end else if (idle_hit) begin
        idle <= 1'b1;
        if (in_frame) begin
          in_frame <= 1'b0;
          // A clean frame is whole bytes plus a single one bit
          if (bit_cnt == 3'd1 && shreg[0]) begin
            rx_stop <= 1'b1;
          end else begin
            rx_error <= 1'b1;
          end
        end
      end else if (sample_now) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7) begin
          rx_strobe <= 1'b1;
        end
      end
    end
  end

  // Bits arrive MSB first
  always_ff @(posedge clk) begin
    if (sample_now) begin
      shreg <= {shreg[6:0], sync2};
      if (bit_cnt == 3'd7) begin
        rx_data <= {shreg[6:0], sync2};
      end
    end
  end

  // The FSM treats each event as exclusive of the others
  assert property (@(posedge clk) disable iff (reset)
    $onehot0({rx_start, rx_stop, rx_error, rx_strobe}))
    else $error("more than one receiver event in a cycle");

endmodule

`default_nettype wire

// File: source/n_serial_tx.sv
// N-serial transmitter that sends response bytes and the stop bit as open-drain low pulses
`timescale 1ns/1ps
`default_nettype none
`include "gc_consts.svh"

module n_serial_tx (
  input  wire        clk,
  input  wire        reset,
  input  wire  [7:0] tx_data,
  input  wire        tx_stopbit,
  input  wire        tx_strobe,
  output logic       tx_busy,
  output logic       line_drive_low
);

  localparam int Q = `GC_QUARTER_CYCLES;
  localparam int QCLK_W = $clog2(Q + 1);

  logic [7:0]        shifter;
  logic [3:0]        symbols_left;
  logic [QCLK_W-1:0] qclk;
  logic [1:0]        quarter;
  logic              quarter_end;
  logic              load;

  assign quarter_end = (qclk == QCLK_W'(Q - 1));
  assign load        = tx_strobe & ~tx_busy;

  // Every symbol is low in quarter 0, low in quarters 1 and 2 only for a zero,
  // and released in quarter 3
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tx_busy        <= 1'b0;
      line_drive_low <= 1'b0;
      symbols_left   <= '0;
      qclk           <= '0;
      quarter        <= '0;
    end else if (load) begin
      tx_busy        <= 1'b1;
      line_drive_low <= 1'b1;
      symbols_left   <= tx_stopbit ? 4'd1 : 4'd8;
      qclk           <= '0;
      quarter        <= '0;
    end else if (tx_busy) begin
      if (!quarter_end) begin
        qclk <= qclk + 1'b1;
      end else begin
        qclk    <= '0;
        quarter <= quarter + 1'b1;
        if (quarter == 2'd3) begin
          symbols_left <= symbols_left - 1'b1;
          if (symbols_left == 4'd1) begin
            tx_busy        <= 1'b0;
            line_drive_low <= 1'b0;
          end else begin
            line_drive_low <= 1'b1;
          end
        end else if (quarter == 2'd2) begin
          line_drive_low <= 1'b0;
        end else begin
          line_drive_low <= ~shifter[7];
        end
      end
    end
  end

  // The stop bit is sent as a lone one in the MSB
  always_ff @(posedge clk) begin
    if (load) begin
      shifter <= tx_stopbit ? 8'h80 : tx_data;
    end else if (tx_busy && quarter_end && quarter == 2'd3) begin
      shifter <= {shifter[6:0], 1'b0};
    end
  end

  // The controller has to wait for the current symbol run to finish
  assert property (@(posedge clk) disable iff (reset)
    tx_strobe |-> !tx_busy)
    else $error("transmit strobe while busy");

endmodule

`default_nettype wire

// File: source/gc_controller.sv
// GameCube controller FSM that parses console requests and sequences the ID, poll and origins replies
`timescale 1ns/1ps
`default_nettype none
`include "gc_consts.svh"

module gc_controller #(
  parameter logic [23:0] CONTROLLER_ID = `GC_CONTROLLER_ID
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     rx_start,
  input  wire                     rx_stop,
  input  wire                     rx_error,
  input  wire  [7:0]              rx_data,
  input  wire                     rx_strobe,
  input  wire gc_host_pkg::pad_state_t pad_state,
  input  wire                     tx_busy,
  output logic [7:0]              tx_data,
  output logic                    tx_stopbit,
  output logic                    tx_strobe,
  output logic                    rumble
);

  import gc_proto_pkg::*;

  // Wide enough for the ten-byte origins reply
  // Shorter replies are left-justified and shifted out from the top
  localparam int SHIFT_W = 80;

  gc_state_e          state;
  logic [SHIFT_W-1:0] shifter;
  logic [3:0]         bytes_left;
  logic               rumble_req;
  logic               rx_abort;
  logic               rx_extra;

  // Anything but a data byte while a request is still arriving
  assign rx_abort = rx_start | rx_stop | rx_error;
  // Anything but the stop once the request is complete
  assign rx_extra = rx_start | rx_error | rx_strobe;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= S_IDLE;
      tx_strobe  <= 1'b0;
      tx_stopbit <= 1'b0;
      bytes_left <= '0;
      rumble_req <= 1'b0;
      rumble     <= 1'b0;
    end else begin
      tx_strobe <= 1'b0;
      case (state)
        // Our own reply echoes back through the receiver, and its stop is ignored here
        S_IDLE: begin
          bytes_left <= '0;
          if (rx_start) begin
            state <= S_RX_CMD;
          end
        end

        // First request byte picks the command
        S_RX_CMD: begin
          if (rx_abort) begin
            state <= S_IDLE;
          end else if (rx_strobe) begin
            case (rx_data)
              GC_CMD_ID:      state <= S_FINISH_ID;
              GC_CMD_POLL:    state <= S_RX_POLL_1;
              GC_CMD_ORIGINS: state <= S_FINISH_ORIGINS;
              default:        state <= S_IDLE;
            endcase
          end
        end

        // Second poll byte has to be 0x03
        S_RX_POLL_1: begin
          if (rx_abort) begin
            state <= S_IDLE;
          end else if (rx_strobe) begin
            state <= (rx_data == GC_CMD_POLL_ARG) ? S_RX_POLL_2 : S_IDLE;
          end
        end

        // Third poll byte carries flags; only bit 0, the rumble motor, is used
        S_RX_POLL_2: begin
          if (rx_abort) begin
            state <= S_IDLE;
          end else if (rx_strobe) begin
            rumble_req <= rx_data[0];
            state      <= S_FINISH_POLL;
          end
        end

        S_FINISH_ID: begin
          if (rx_extra) begin
            state <= S_IDLE;
          end else if (rx_stop) begin
            shifter    <= {CONTROLLER_ID, 56'h0};
            bytes_left <= 4'd3;
            state      <= S_TX_BYTE;
          end
        end

        // Rumble changes only once the whole poll has arrived intact
        S_FINISH_POLL: begin
          if (rx_extra) begin
            state <= S_IDLE;
          end else if (rx_stop) begin
            rumble     <= rumble_req;
            shifter    <= {pad_state, 16'h0};
            bytes_left <= 4'd8;
            state      <= S_TX_BYTE;
          end
        end

        // Button bytes are live, the axis origins and the tail are fixed
        S_FINISH_ORIGINS: begin
          if (rx_extra) begin
            state <= S_IDLE;
          end else if (rx_stop) begin
            shifter    <= {pad_state[63:48], GC_ORIGINS_TAIL};
            bytes_left <= 4'd10;
            state      <= S_TX_BYTE;
          end
        end

        S_TX_BYTE: begin
          if (!tx_busy) begin
            tx_data    <= shifter[SHIFT_W-1 -: 8];
            shifter    <= {shifter[SHIFT_W-9:0], 8'h00};
            tx_stopbit <= 1'b0;
            tx_strobe  <= 1'b1;
            bytes_left <= bytes_left - 1'b1;
            state      <= S_TX_WAIT;
          end
        end

        // tx_busy is not valid until one cycle after the strobe
        S_TX_WAIT: begin
          state <= (bytes_left == 4'd0) ? S_TX_STOPBIT : S_TX_BYTE;
        end

        S_TX_STOPBIT: begin
          if (!tx_busy) begin
            tx_stopbit <= 1'b1;
            tx_strobe  <= 1'b1;
            state      <= S_IDLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

  // The longest reply is the ten-byte origins packet
  assert property (@(posedge clk) disable iff (reset)
    bytes_left <= 4'd10)
    else $error("reply byte count out of range");

endmodule

`default_nettype wire

// File: source/gc_emulator.sv
// Top level of one emulated GameCube controller on a single joybus line, with a host register port
`timescale 1ns/1ps
`default_nettype none

module gc_emulator (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         line_in,
  output logic                        line_drive_low,
  input  wire                         host_write,
  input  wire                         host_commit,
  input  wire gc_host_pkg::pad_byte_idx_t host_addr,
  input  wire  [7:0]                  host_wdata,
  output logic                        rumble
);

  import gc_host_pkg::*;

  pad_state_t pad_state;
  logic       rx_start;
  logic       rx_stop;
  logic       rx_error;
  logic [7:0] rx_data;
  logic       rx_strobe;
  logic [7:0] tx_data;
  logic       tx_stopbit;
  logic       tx_strobe;
  logic       tx_busy;

  // Committed pad report that the controller returns to polls
  gc_state_regs state_regs_i (
    .clk         (clk),
    .reset       (reset),
    .host_write  (host_write),
    .host_commit (host_commit),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .pad_state   (pad_state)
  );

  // The receiver also hears our own reply, which the FSM ignores while sending
  n_serial_rx rx_i (
    .clk       (clk),
    .reset     (reset),
    .line_in   (line_in),
    .rx_start  (rx_start),
    .rx_stop   (rx_stop),
    .rx_error  (rx_error),
    .rx_data   (rx_data),
    .rx_strobe (rx_strobe)
  );

  gc_controller controller_i (
    .clk        (clk),
    .reset      (reset),
    .rx_start   (rx_start),
    .rx_stop    (rx_stop),
    .rx_error   (rx_error),
    .rx_data    (rx_data),
    .rx_strobe  (rx_strobe),
    .pad_state  (pad_state),
    .tx_busy    (tx_busy),
    .tx_data    (tx_data),
    .tx_stopbit (tx_stopbit),
    .tx_strobe  (tx_strobe),
    .rumble     (rumble)
  );

  // line_drive_low goes to the external open-drain buffer
  n_serial_tx tx_i (
    .clk            (clk),
    .reset          (reset),
    .tx_data        (tx_data),
    .tx_stopbit     (tx_stopbit),
    .tx_strobe      (tx_strobe),
    .tx_busy        (tx_busy),
    .line_drive_low (line_drive_low)
  );

endmodule

`default_nettype wire

// File: dv/gc_emulator_tb.sv
// Directed testbench for the joybus controller emulator, compiled through the file list as top gc_emulator_tb
`timescale 1ns/1ps
`default_nettype none
`include "gc_consts.svh"

module gc_emulator_tb;

  import gc_host_pkg::*;
  import gc_proto_pkg::*;

  typedef logic [7:0] byte_q_t [$];

  localparam int Q = `GC_QUARTER_CYCLES;
  // A reply has to begin within this many quarters after the request ends
  localparam int REPLY_WAIT_Q = 40;
  // Two bit times of high line after a pulse close the reply frame
  localparam int FRAME_GAP_CYCLES = 8 * Q;
  // No valid symbol stays low for more than three quarters
  localparam int LOW_MAX_CYCLES = 5 * Q;

  logic          clk;
  logic          reset;
  logic          tb_low;
  wire           line_in;
  logic          line_drive_low;
  logic          host_write;
  logic          host_commit;
  pad_byte_idx_t host_addr;
  logic [7:0]    host_wdata;
  logic          rumble;

  // Reference model of the host registers and the rumble flag
  logic [7:0]  staged [8];
  logic [7:0]  committed [8];
  logic        rumble_model;
  logic [15:0] lfsr_state;
  string       current_test;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  // Wired-AND line that either side can pull low
  assign line_in = ~(tb_low | line_drive_low);

  gc_emulator gc_emulator_i (
    .clk            (clk),
    .reset          (reset),
    .line_in        (line_in),
    .line_drive_low (line_drive_low),
    .host_write     (host_write),
    .host_commit    (host_commit),
    .host_addr      (host_addr),
    .host_wdata     (host_wdata),
    .rumble         (rumble)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_byte(input string what, input logic [7:0] expected,
                            input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s %s: expected %02h, actual %02h", current_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("ERROR %s %s: expected %0d, actual %0d", current_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      $display("%s failed: %s", current_test, what);
      test_errors++;
    end
  endtask

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit of the byte
  task automatic draw_random_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic write_pad_byte(input int idx, input logic [7:0] data);
    @(posedge clk);
    host_write <= 1'b1;
    host_addr  <= pad_byte_idx_t'(idx);
    host_wdata <= data;
    @(posedge clk);
    host_write <= 1'b0;
    staged[idx] = data;
  endtask

  task automatic commit_pad();
    @(posedge clk);
    host_commit <= 1'b1;
    @(posedge clk);
    host_commit <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      committed[i] = staged[i];
    end
  endtask

  // A one is low for one quarter, a zero for three, and every symbol is four quarters long
  // Entered and left on a rising edge
  task automatic send_symbol(input logic one);
    int low_cycles;
    low_cycles = one ? Q : 3 * Q;
    tb_low <= 1'b1;
    repeat (low_cycles) @(posedge clk);
    tb_low <= 1'b0;
    repeat (4 * Q - low_cycles) @(posedge clk);
  endtask

  // Request bytes MSB first, then the console stop bit
  task automatic send_request(input byte_q_t bytes);
    @(posedge clk);
    foreach (bytes[i]) begin
      for (int b = 7; b >= 0; b--) begin
        send_symbol(bytes[i][b]);
      end
    end
    send_symbol(1'b1);
  endtask

  task automatic send_single(input logic [7:0] cmd);
    byte_q_t req;
    req = {};
    req.push_back(cmd);
    send_request(req);
  endtask

  // A complete poll sets the motor to bit 0 of the flags
  task automatic send_poll(input logic [7:0] flags);
    byte_q_t req;
    req = {};
    req.push_back(GC_CMD_POLL);
    req.push_back(GC_CMD_POLL_ARG);
    req.push_back(flags);
    send_request(req);
    rumble_model = flags[0];
  endtask

  // Decodes the reply from pulse widths, sampled on falling clock edges
  // Returns with responded low if the line never falls before the timeout
  task automatic receive_reply(output byte_q_t got, output logic responded);
    int         waited;
    int         width;
    int         nbits;
    logic [7:0] shreg;
    logic       last_bit;
    logic       done;
    got       = {};
    responded = 1'b0;
    nbits     = 0;
    shreg     = '0;
    last_bit  = 1'b0;
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (line_in && waited < REPLY_WAIT_Q * Q);
    if (line_in) begin
      return;
    end
    responded = 1'b1;
    done      = 1'b0;
    while (!done) begin
      width = 0;
      while (!line_in && width <= LOW_MAX_CYCLES) begin
        width++;
        @(negedge clk);
      end
      if (!line_in) begin
        check_true(1'b0, "reply pulse held the line low for too long");
        return;
      end
      // Anything shorter than two quarters is a one
      last_bit = (width < 2 * Q);
      nbits++;
      shreg = {shreg[6:0], last_bit};
      if (nbits % 8 == 0) begin
        got.push_back(shreg);
      end
      waited = 0;
      while (line_in && waited < FRAME_GAP_CYCLES) begin
        @(negedge clk);
        waited++;
      end
      done = line_in;
    end
    check_true((nbits % 8 == 1) && last_bit, "reply did not end with a stop bit");
  endtask

  task automatic expect_reply(input byte_q_t expected);
    byte_q_t got;
    logic    responded;
    receive_reply(got, responded);
    check_true(responded, "no reply before the timeout");
    check_count("reply length", expected.size(), got.size());
    for (int i = 0; i < expected.size() && i < got.size(); i++) begin
      check_byte($sformatf("reply byte %0d", i), expected[i], got[i]);
    end
  endtask

  task automatic expect_silence();
    byte_q_t got;
    logic    responded;
    receive_reply(got, responded);
    check_true(!responded, "controller answered a request it should ignore");
  endtask

  // Standard pad ID
  task automatic id_reply(output byte_q_t q);
    q = {};
    q.push_back(8'h09);
    q.push_back(8'h00);
    q.push_back(8'h00);
  endtask

  task automatic committed_reply(output byte_q_t q);
    q = {};
    for (int i = 0; i < 8; i++) begin
      q.push_back(committed[i]);
    end
  endtask

  task automatic start_test(input string name);
    current_test = name;
    test_errors  = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %-16s %s, %0d failed checks", current_test,
             (test_errors == 0) ? "passed" : "failed", test_errors);
  endtask

  task automatic test_reset_idle();
    int   falls;
    logic prev;
    start_test("reset_idle");
    @(negedge clk);
    check_byte("line_drive_low", 8'h00, {7'b0, line_drive_low});
    check_byte("rumble", 8'h00, {7'b0, rumble});
    falls = 0;
    prev  = line_in;
    for (int c = 0; c < 200 * Q; c++) begin
      @(negedge clk);
      if (prev && !line_in) begin
        falls++;
      end
      prev = line_in;
    end
    check_count("falling edges while idle", 0, falls);
    finish_test();
  endtask

  task automatic test_id_request();
    byte_q_t expected;
    start_test("id_request");
    send_single(GC_CMD_ID);
    id_reply(expected);
    expect_reply(expected);
    finish_test();
  endtask

  // Staged bytes stay invisible until the commit
  task automatic test_poll_commit();
    logic [7:0] pattern [8];
    byte_q_t    expected;
    pattern = '{8'h01, 8'h80, 8'h7b, 8'h85, 8'h90, 8'h6a, 8'h22, 8'h3c};
    start_test("poll_commit");
    for (int i = 0; i < 8; i++) begin
      write_pad_byte(i, pattern[i]);
    end
    send_poll(8'h01);
    committed_reply(expected);
    expect_reply(expected);
    check_byte("rumble", 8'h01, {7'b0, rumble});
    commit_pad();
    send_poll(8'h00);
    committed_reply(expected);
    expect_reply(expected);
    check_byte("rumble", 8'h00, {7'b0, rumble});
    finish_test();
  endtask

  task automatic test_origins();
    byte_q_t expected;
    start_test("origins");
    send_single(GC_CMD_ORIGINS);
    expected = {committed[0], committed[1], 8'h80, 8'h80, 8'h80, 8'h80,
                8'h00, 8'h00, 8'h02, 8'h02};
    expect_reply(expected);
    finish_test();
  endtask

  task automatic test_invalid_requests();
    byte_q_t req;
    byte_q_t expected;
    start_test("invalid_requests");
    send_single(8'h55);
    expect_silence();
    // Poll with a wrong second byte that would turn the motor on
    req = {};
    req.push_back(GC_CMD_POLL);
    req.push_back(8'h07);
    req.push_back(8'h01);
    send_request(req);
    expect_silence();
    // Poll cut off before the flags byte
    req = {};
    req.push_back(GC_CMD_POLL);
    req.push_back(GC_CMD_POLL_ARG);
    send_request(req);
    expect_silence();
    check_byte("rumble", {7'b0, rumble_model}, {7'b0, rumble});
    send_single(GC_CMD_ID);
    id_reply(expected);
    expect_reply(expected);
    finish_test();
  endtask

  task automatic test_random_rounds();
    logic [7:0] data;
    byte_q_t    expected;
    start_test("random_rounds");
    for (int round = 0; round < 10; round++) begin
      for (int i = 0; i < 8; i++) begin
        draw_random_byte(data);
        write_pad_byte(i, data);
      end
      commit_pad();
      send_poll(8'h00);
      committed_reply(expected);
      expect_reply(expected);
    end
    finish_test();
  endtask

  initial begin
    lfsr_state   = 16'd42492;
    current_test = "none";
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    rumble_model = 1'b0;
    // Live pad word comes out of reset as zero
    for (int i = 0; i < 8; i++) begin
      staged[i]    = 8'h00;
      committed[i] = 8'h00;
    end
    reset       <= 1'b1;
    tb_low      <= 1'b0;
    host_write  <= 1'b0;
    host_commit <= 1'b0;
    host_addr   <= '0;
    host_wdata  <= 8'h00;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_reset_idle();
    test_id_request();
    test_poll_commit();
    test_origins();
    test_invalid_requests();
    test_random_rounds();

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gc_emulator.f
+incdir+source
source/gc_proto_pkg.sv
source/gc_host_pkg.sv
source/gc_state_regs.sv
source/n_serial_rx.sv
source/n_serial_tx.sv
source/gc_controller.sv
source/gc_emulator.sv
dv/gc_emulator_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the joybus controller emulator testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  -f gc_emulator.f \
  --top-module gc_emulator_tb \
  -Mdir "$build_dir" \
  -o gc_emulator_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/gc_emulator_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$log_file"; then
  exit 1
fi
exit 0
